// File: include/common.svh
/* Procyon common widths
   Bit widths shared by the core's type package */
`ifndef COMMON_SVH
`define COMMON_SVH

`define PROCYON_DATA_WIDTH   32
`define PROCYON_ADDR_WIDTH   32
`define PROCYON_TAG_WIDTH    6
`define PROCYON_OPCODE_WIDTH 7

`endif

// File: verilog/procyon_types.sv
/* Procyon types package
   Width typedefs, RV32I opcode and branch encodings, ALU function enum */
`include "common.svh"

package procyon_types;

    localparam int DATA_WIDTH     = `PROCYON_DATA_WIDTH;
    localparam int ADDR_WIDTH     = `PROCYON_ADDR_WIDTH;
    localparam int TAG_WIDTH      = `PROCYON_TAG_WIDTH;
    localparam int OPCODE_WIDTH   = `PROCYON_OPCODE_WIDTH;
    localparam int SHAMT_WIDTH    = 5;
    localparam int ALU_FUNC_WIDTH = 4;

    // Size of one instruction in bytes, for the return address
    localparam int INSN_BYTES     = 4;

    typedef logic [DATA_WIDTH-1:0]   procyon_data_t;
    typedef logic [ADDR_WIDTH-1:0]   procyon_addr_t;
    typedef logic [TAG_WIDTH-1:0]    procyon_tag_t;
    typedef logic [OPCODE_WIDTH-1:0] procyon_opcode_t;
    typedef logic [SHAMT_WIDTH-1:0]  procyon_shamt_t;

    typedef enum logic [ALU_FUNC_WIDTH-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } procyon_alu_func_t;

    // RV32I major opcodes handled by the integer unit
    localparam procyon_opcode_t OPCODE_OP     = 7'b0110011;
    localparam procyon_opcode_t OPCODE_OPIMM  = 7'b0010011;
    localparam procyon_opcode_t OPCODE_LUI    = 7'b0110111;
    localparam procyon_opcode_t OPCODE_AUIPC  = 7'b0010111;
    localparam procyon_opcode_t OPCODE_JAL    = 7'b1101111;
    localparam procyon_opcode_t OPCODE_JALR   = 7'b1100111;
    localparam procyon_opcode_t OPCODE_BRANCH = 7'b1100011;

    // Branch funct3 encodings
    localparam logic [2:0] BEQ  = 3'b000;
    localparam logic [2:0] BNE  = 3'b001;
    localparam logic [2:0] BLT  = 3'b100;
    localparam logic [2:0] BGE  = 3'b101;
    localparam logic [2:0] BLTU = 3'b110;
    localparam logic [2:0] BGEU = 3'b111;

endpackage

// File: verilog/ieu_id.sv
/* IEU decode stage
   Turns opcode and instruction word into ALU function, operands and flags */
module ieu_id
    import procyon_types::*;
(
    input  logic              i_valid,
    input  procyon_opcode_t   i_opcode,
    input  procyon_data_t     i_insn,
    input  procyon_addr_t     i_iaddr,
    input  procyon_data_t     i_src_a,
    input  procyon_data_t     i_src_b,
    input  procyon_tag_t      i_tag,

    output procyon_alu_func_t o_alu_func,
    output procyon_data_t     o_src_a,
    output procyon_data_t     o_src_b,
    output procyon_addr_t     o_iaddr,
    output procyon_data_t     o_imm_b,
    output procyon_shamt_t    o_shamt,
    output procyon_tag_t      o_tag,
    output logic              o_jmp,
    output logic              o_br,
    output logic              o_valid
);

    logic [2:0]    funct3;
    logic          funct7_b5;
    logic          br_negate;
    procyon_data_t imm_i;
    procyon_data_t imm_u;
    procyon_data_t imm_j;

    // Shared funct3 decode for OP and OP-IMM
    function automatic procyon_alu_func_t alu_decode(input logic [2:0] f3,
                                                     input logic       sub_en,
                                                     input logic       sra_en);
        case (f3)
            3'b000:  return sub_en ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sra_en ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign funct3    = i_insn[14:12];
    assign funct7_b5 = i_insn[30];
    assign br_negate = (funct3 == BNE) || (funct3 == BGE) || (funct3 == BGEU);

    assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
    assign imm_u = {i_insn[31:12], 12'b0};
    assign imm_j = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

    // Branch offset, added to iaddr in EX
    assign o_imm_b = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};

    assign o_iaddr = i_iaddr;
    assign o_tag   = i_tag;
    assign o_valid = i_valid;

    always_comb begin
        o_alu_func = ALU_ADD;
        o_src_a    = i_src_a;
        o_src_b    = i_src_b;
        o_shamt    = i_src_b[SHAMT_WIDTH-1:0];
        o_jmp      = 1'b0;
        o_br       = 1'b0;

        case (i_opcode)
            OPCODE_OP: begin
                o_alu_func = alu_decode(funct3, funct7_b5, funct7_b5);
            end
            OPCODE_OPIMM: begin
                o_alu_func = alu_decode(funct3, 1'b0, funct7_b5);
                o_src_b    = imm_i;
                o_shamt    = i_insn[24:20];
            end
            OPCODE_LUI: begin
                o_src_a = '0;
                o_src_b = imm_u;
            end
            OPCODE_AUIPC: begin
                o_src_a = i_iaddr;
                o_src_b = imm_u;
            end
            OPCODE_JAL: begin
                o_src_a = i_iaddr;
                o_src_b = imm_j;
                o_shamt = '0;
                o_jmp   = 1'b1;
            end
            OPCODE_JALR: begin
                // Shamt bit 0 asks EX to clear target bit 0
                o_src_b = imm_i;
                o_shamt = SHAMT_WIDTH'(1);
                o_jmp   = 1'b1;
            end
            OPCODE_BRANCH: begin
                o_br    = 1'b1;
                o_shamt = {br_negate, {(SHAMT_WIDTH-1){1'b0}}};
                case (funct3)
                    BEQ, BNE:   o_alu_func = ALU_SUB;
                    BLT, BGE:   o_alu_func = ALU_SLT;
                    BLTU, BGEU: o_alu_func = ALU_SLTU;
                    default:    o_alu_func = ALU_SUB;
                endcase
            end
            default: begin
                o_alu_func = ALU_ADD;
            end
        endcase
    end

endmodule

// File: verilog/ieu_ex.sv
/* IEU execute stage
   ALU, branch comparator and target adder feeding the CDB registers */
module ieu_ex
    import procyon_types::*;
(
    input  procyon_alu_func_t i_alu_func,
    input  procyon_data_t     i_src_a,
    input  procyon_data_t     i_src_b,
    input  procyon_addr_t     i_iaddr,
    input  procyon_data_t     i_imm_b,
    input  procyon_shamt_t    i_shamt,
    input  procyon_tag_t      i_tag,
    input  logic              i_jmp,
    input  logic              i_br,
    input  logic              i_valid,

    output procyon_data_t     o_data,
    output procyon_addr_t     o_addr,
    output procyon_tag_t      o_tag,
    output logic              o_redirect,
    output logic              o_valid
);

    procyon_data_t alu_res;
    procyon_addr_t br_target;
    procyon_addr_t ret_addr;
    procyon_addr_t jmp_target;
    logic          br_cond;
    logic          br_taken;

    always_comb begin
        case (i_alu_func)
            ALU_ADD:  alu_res = i_src_a + i_src_b;
            ALU_SUB:  alu_res = i_src_a - i_src_b;
            ALU_AND:  alu_res = i_src_a & i_src_b;
            ALU_OR:   alu_res = i_src_a | i_src_b;
            ALU_XOR:  alu_res = i_src_a ^ i_src_b;
            ALU_SLL:  alu_res = i_src_a << i_shamt;
            ALU_SRL:  alu_res = i_src_a >> i_shamt;
            ALU_SRA:  alu_res = $signed(i_src_a) >>> i_shamt;
            ALU_SLT:  alu_res = DATA_WIDTH'($signed(i_src_a) < $signed(i_src_b));
            ALU_SLTU: alu_res = DATA_WIDTH'(i_src_a < i_src_b);
            default:  alu_res = i_src_a + i_src_b;
        endcase
    end

    // BEQ/BNE compare through SUB, the others through SLT/SLTU
    assign br_cond  = (i_alu_func == ALU_SUB) ? (alu_res == '0) : alu_res[0];

    // Top shamt bit inverts the outcome for BNE, BGE and BGEU
    assign br_taken = i_br & (br_cond ^ i_shamt[SHAMT_WIDTH-1]);

    assign br_target = i_iaddr + i_imm_b;
    assign ret_addr  = i_iaddr + ADDR_WIDTH'(INSN_BYTES);

    // Jump target from the ALU adder, bit 0 dropped for JALR
    assign jmp_target = {alu_res[DATA_WIDTH-1:1], alu_res[0] & ~i_shamt[0]};

    always_comb begin
        if (i_jmp) begin
            o_data = ret_addr;
            o_addr = jmp_target;
        end else if (i_br) begin
            o_data = '0;
            o_addr = br_taken ? br_target : i_iaddr;
        end else begin
            o_data = alu_res;
            o_addr = i_iaddr;
        end
    end

    // No prediction, so every taken control transfer redirects
    assign o_redirect = i_jmp | br_taken;
    assign o_tag      = i_tag;
    assign o_valid    = i_valid;

endmodule

// File: verilog/ieu.sv
/* Integer execution unit
   ID and EX stages with pipeline registers, result written to the CDB */
module ieu
    import procyon_types::*;
(
    input  logic            clk,
    input  logic            n_rst,

    input  logic            i_flush,

    input  logic            i_fu_valid,
    input  procyon_opcode_t i_fu_opcode,
    input  procyon_addr_t   i_fu_iaddr,
    input  procyon_data_t   i_fu_insn,
    input  procyon_data_t   i_fu_src_a,
    input  procyon_data_t   i_fu_src_b,
    input  procyon_tag_t    i_fu_tag,

    // Common data bus
    output logic            o_cdb_en,
    output logic            o_cdb_redirect,
    output procyon_data_t   o_cdb_data,
    output procyon_addr_t   o_cdb_addr,
    output procyon_tag_t    o_cdb_tag
);

    procyon_alu_func_t id_alu_func;
    procyon_data_t     id_src_a;
    procyon_data_t     id_src_b;
    procyon_addr_t     id_iaddr;
    procyon_data_t     id_imm_b;
    procyon_shamt_t    id_shamt;
    procyon_tag_t      id_tag;
    logic              id_jmp;
    logic              id_br;
    logic              id_valid;

    procyon_alu_func_t id_alu_func_q;
    procyon_data_t     id_src_a_q;
    procyon_data_t     id_src_b_q;
    procyon_addr_t     id_iaddr_q;
    procyon_data_t     id_imm_b_q;
    procyon_shamt_t    id_shamt_q;
    procyon_tag_t      id_tag_q;
    logic              id_jmp_q;
    logic              id_br_q;
    logic              id_valid_q;

    procyon_data_t     ex_data;
    procyon_addr_t     ex_addr;
    procyon_tag_t      ex_tag;
    logic              ex_redirect;
    logic              ex_valid;

    procyon_data_t     ex_data_q;
    procyon_addr_t     ex_addr_q;
    procyon_tag_t      ex_tag_q;
    logic              ex_redirect_q;
    logic              ex_valid_q;

    ieu_id u_ieu_id (
        .i_valid    (i_fu_valid),
        .i_opcode   (i_fu_opcode),
        .i_insn     (i_fu_insn),
        .i_iaddr    (i_fu_iaddr),
        .i_src_a    (i_fu_src_a),
        .i_src_b    (i_fu_src_b),
        .i_tag      (i_fu_tag),
        .o_alu_func (id_alu_func),
        .o_src_a    (id_src_a),
        .o_src_b    (id_src_b),
        .o_iaddr    (id_iaddr),
        .o_imm_b    (id_imm_b),
        .o_shamt    (id_shamt),
        .o_tag      (id_tag),
        .o_jmp      (id_jmp),
        .o_br       (id_br),
        .o_valid    (id_valid)
    );

    // Flush drops both stages and the operation offered in the same cycle
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            id_valid_q <= 1'b0;
            ex_valid_q <= 1'b0;
        end else begin
            id_valid_q <= id_valid & ~i_flush;
            ex_valid_q <= ex_valid & ~i_flush;
        end
    end

    // ID to EX payload
    always_ff @(posedge clk) begin
        id_alu_func_q <= id_alu_func;
        id_src_a_q    <= id_src_a;
        id_src_b_q    <= id_src_b;
        id_iaddr_q    <= id_iaddr;
        id_imm_b_q    <= id_imm_b;
        id_shamt_q    <= id_shamt;
        id_tag_q      <= id_tag;
        id_jmp_q      <= id_jmp;
        id_br_q       <= id_br;
    end

    ieu_ex u_ieu_ex (
        .i_alu_func (id_alu_func_q),
        .i_src_a    (id_src_a_q),
        .i_src_b    (id_src_b_q),
        .i_iaddr    (id_iaddr_q),
        .i_imm_b    (id_imm_b_q),
        .i_shamt    (id_shamt_q),
        .i_tag      (id_tag_q),
        .i_jmp      (id_jmp_q),
        .i_br       (id_br_q),
        .i_valid    (id_valid_q),
        .o_data     (ex_data),
        .o_addr     (ex_addr),
        .o_tag      (ex_tag),
        .o_redirect (ex_redirect),
        .o_valid    (ex_valid)
    );

    // EX to CDB payload
    always_ff @(posedge clk) begin
        ex_data_q     <= ex_data;
        ex_addr_q     <= ex_addr;
        ex_tag_q      <= ex_tag;
        ex_redirect_q <= ex_redirect;
    end

    assign o_cdb_en       = ex_valid_q;
    // Redirect only qualifies a live result
    assign o_cdb_redirect = ex_valid_q & ex_redirect_q;
    assign o_cdb_data     = ex_data_q;
    assign o_cdb_addr     = ex_addr_q;
    assign o_cdb_tag      = ex_tag_q;

endmodule

// File: dv/clk_gen.sv
/* Testbench clock source, period of 100 time units */
module clk_gen (
    output logic o_clk
);

    localparam int HALF_PERIOD = 50;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

// File: dv/ieu_checker.sv
/* IEU port checker
   Assertions on the CDB outputs, bound into every ieu instance */
module ieu_checker
    import procyon_types::*;
(
    input logic         clk,
    input logic         n_rst,
    input logic         i_flush,
    input logic         i_fu_valid,
    input logic         i_cdb_en,
    input logic         i_cdb_redirect,
    input procyon_tag_t i_cdb_tag
);

    // Redirect is a known level whenever a result is on the bus
    redirect_known: assert property (@(posedge clk) disable iff (!n_rst)
        i_cdb_en |-> !$isunknown(i_cdb_redirect))
        else $error("CDB redirect unknown while CDB enable is high");

    // Flush empties ID and drops the input of the same cycle
    quiet_after_flush: assert property (@(posedge clk) disable iff (!n_rst)
        (i_flush || $past(i_flush)) |=> !i_cdb_en)
        else $error("CDB pulse within two cycles of a flush");

    // Accepted op with no flush behind it reaches the CDB
    result_latency: assert property (@(posedge clk) disable iff (!n_rst)
        ($past(i_fu_valid) && !$past(i_flush) && !i_flush) |=> i_cdb_en)
        else $error("Accepted operation missing from the CDB after two cycles");

    tag_known: assert property (@(posedge clk) disable iff (!n_rst)
        i_cdb_en |-> !$isunknown(i_cdb_tag))
        else $error("CDB tag unknown while CDB enable is high");

endmodule

// File: dv/ieu_tb.sv
/* IEU testbench
   Plays pattern records into the execution unit and checks every CDB result */
module ieu_tb
    import procyon_types::*;
();

    localparam int MAX_PATS     = 64;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 10;
    localparam int NUM_GROUPS   = 7;

    // One line of the pattern file, fields padded to whole hex digits
    typedef struct packed {
        logic [3:0]  grp;
        logic [3:0]  ctrl;
        logic [7:0]  opcode;
        logic [31:0] iaddr;
        logic [31:0] insn;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [7:0]  tag;
        logic [31:0] exp_data;
        logic [31:0] exp_addr;
        logic [3:0]  exp_redirect;
    } pattern_t;

    typedef struct packed {
        logic [31:0]   due;
        logic [3:0]    grp;
        procyon_data_t data;
        procyon_addr_t addr;
        procyon_tag_t  tag;
        logic          redirect;
    } expect_t;

    logic            clk;
    logic            n_rst;
    logic            flush;
    logic            fu_valid;
    procyon_opcode_t fu_opcode;
    procyon_addr_t   fu_iaddr;
    procyon_data_t   fu_insn;
    procyon_data_t   fu_src_a;
    procyon_data_t   fu_src_b;
    procyon_tag_t    fu_tag;
    logic            cdb_en;
    logic            cdb_redirect;
    procyon_data_t   cdb_data;
    procyon_addr_t   cdb_addr;
    procyon_tag_t    cdb_tag;

    pattern_t pats [0:MAX_PATS-1];
    expect_t  exp_q [$];
    int       num_pats = 0;
    int       cycle    = 0;
    int       limit    = 1000;
    int       checks   = 0;
    int       errors   = 0;
    int       cur_grp  = 1;
    int       grp_checks [NUM_GROUPS];
    int       grp_errors [NUM_GROUPS];

    clk_gen u_clk_gen (
        .o_clk (clk)
    );

    ieu u_ieu (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (flush),
        .i_fu_valid     (fu_valid),
        .i_fu_opcode    (fu_opcode),
        .i_fu_iaddr     (fu_iaddr),
        .i_fu_insn      (fu_insn),
        .i_fu_src_a     (fu_src_a),
        .i_fu_src_b     (fu_src_b),
        .i_fu_tag       (fu_tag),
        .o_cdb_en       (cdb_en),
        .o_cdb_redirect (cdb_redirect),
        .o_cdb_data     (cdb_data),
        .o_cdb_addr     (cdb_addr),
        .o_cdb_tag      (cdb_tag)
    );

    bind ieu ieu_checker u_ieu_checker (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_fu_valid     (i_fu_valid),
        .i_cdb_en       (o_cdb_en),
        .i_cdb_redirect (o_cdb_redirect),
        .i_cdb_tag      (o_cdb_tag)
    );

    function automatic string group_name(input int g);
        case (g)
            1:       return "reset";
            2:       return "alu ops";
            3:       return "jumps";
            4:       return "branches";
            5:       return "back-to-back";
            6:       return "flush";
            default: return "unknown";
        endcase
    endfunction

    task automatic note_check(input logic ok);
        checks++;
        grp_checks[cur_grp]++;
        if (!ok) begin
            errors++;
            grp_errors[cur_grp]++;
        end
    endtask

    task automatic check_data(input string name, input procyon_data_t got,
                              input procyon_data_t exp);
        if (got !== exp)
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        note_check(got === exp);
    endtask

    task automatic check_addr(input string name, input procyon_addr_t got,
                              input procyon_addr_t exp);
        if (got !== exp)
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        note_check(got === exp);
    endtask

    task automatic check_tag(input string name, input procyon_tag_t got,
                             input procyon_tag_t exp);
        if (got !== exp)
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        note_check(got === exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
        note_check(got === exp);
    endtask

    task automatic report_group(input int g);
        $display("Group %0d (%s): %0d checks, %0d errors", g, group_name(g),
                 grp_checks[g], grp_errors[g]);
    endtask

    task automatic drive_record(input pattern_t p);
        flush     = p.ctrl[1];
        fu_valid  = p.ctrl[0];
        fu_opcode = p.opcode[OPCODE_WIDTH-1:0];
        fu_iaddr  = p.iaddr;
        fu_insn   = p.insn;
        fu_src_a  = p.src_a;
        fu_src_b  = p.src_b;
        fu_tag    = p.tag[TAG_WIDTH-1:0];
    endtask

    task automatic expect_result(input pattern_t p, input int due);
        expect_t e;
        e.due      = due;
        e.grp      = p.grp;
        e.data     = p.exp_data;
        e.addr     = p.exp_addr;
        e.tag      = p.tag[TAG_WIDTH-1:0];
        e.redirect = p.exp_redirect[0];
        exp_q.push_back(e);
    endtask

    initial begin
        logic next_flush;
        n_rst = 1'b0;
        drive_record('0);
        $readmemh("dv/ieu_patterns.txt", pats);
        while (num_pats < MAX_PATS && !$isunknown(pats[num_pats]))
            num_pats++;
        limit = 4 * num_pats + 40;
        if (num_pats == 0) begin
            $display("Error: no records were read from the pattern file");
            errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        n_rst = 1'b1;
        for (int i = 0; i < num_pats; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_record(pats[i]);
            // A flush one cycle later still catches this op in the ID register
            next_flush = (i + 1 < num_pats) && pats[i + 1].ctrl[1];
            if (pats[i].ctrl[0] && !pats[i].ctrl[1] && !next_flush)
                expect_result(pats[i], cycle + 2);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        drive_record('0);
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        report_group(cur_grp);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // Outputs are sampled mid-cycle, away from the drive edge
    always @(negedge clk) begin : monitor
        expect_t head;
        if (!n_rst) begin
            check_bit("o_cdb_en", cdb_en, 1'b0);
            check_bit("o_cdb_redirect", cdb_redirect, 1'b0);
        end else if (cdb_en) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: CDB pulse with tag %h while no result was due",
                         $time, cdb_tag);
                note_check(1'b0);
            end else begin
                head = exp_q.pop_front();
                if (head.grp != cur_grp) begin
                    report_group(cur_grp);
                    cur_grp = head.grp;
                end
                if (head.due != cycle)
                    $display("Error at %0t: tag %h arrived in cycle %0d, due in cycle %0d",
                             $time, head.tag, cycle, head.due);
                note_check(head.due == cycle);
                check_data("o_cdb_data", cdb_data, head.data);
                check_addr("o_cdb_addr", cdb_addr, head.addr);
                check_tag("o_cdb_tag", cdb_tag, head.tag);
                check_bit("o_cdb_redirect", cdb_redirect, head.redirect);
            end
        end else begin
            // No redirect may leak out while the bus is idle
            check_bit("o_cdb_redirect", cdb_redirect, 1'b0);
            if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
                head = exp_q.pop_front();
                $display("Error at %0t: no CDB pulse for tag %h, due in cycle %0d",
                         $time, head.tag, head.due);
                note_check(1'b0);
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            $display("Error: run did not finish within %0d cycles", limit);
            $display("test failed");
            $finish;
        end
    end

endmodule

// File: filelist.f
+incdir+include
verilog/procyon_types.sv
verilog/ieu_id.sv
verilog/ieu_ex.sv
verilog/ieu.sv
dv/clk_gen.sv
dv/ieu_checker.sv
dv/ieu_tb.sv

// File: dv/ieu_patterns.txt
// grp ctrl opcode iaddr insn src_a src_b tag exp_data exp_addr exp_redirect
// ctrl bit 0 is valid and bit 1 is flush, ctrl 0 is an idle cycle
// group 2: OP, OP-IMM, LUI, AUIPC
2_1_33_00001000_00000033_00000005_00000007_01_0000000c_00001000_0
2_1_33_00001004_40000033_00000003_00000005_02_fffffffe_00001004_0
2_1_33_00001008_00007033_f0f0f0f0_0ff00ff0_03_00f000f0_00001008_0
2_1_33_0000100c_00006033_f0000000_0000000f_04_f000000f_0000100c_0
2_1_33_00001010_00004033_ffff0000_0f0f0f0f_05_f0f00f0f_00001010_0
2_1_33_00001014_00001033_00000001_00000024_06_00000010_00001014_0
2_1_33_00001018_00005033_80000000_0000001f_07_00000001_00001018_0
2_1_33_0000101c_40005033_80000000_00000004_08_f8000000_0000101c_0
2_1_33_00001020_00002033_ffffffff_00000001_09_00000001_00001020_0
2_1_33_00001024_00003033_ffffffff_00000001_0a_00000000_00001024_0
2_1_13_00001028_fff00013_00000010_12345678_0b_0000000f_00001028_0
2_1_13_0000102c_00301013_00000011_0000001f_0c_00000088_0000102c_0
2_1_13_00001030_40805013_80000000_00000000_0d_ff800000_00001030_0
2_1_13_00001034_00405013_f0000000_00000000_0e_0f000000_00001034_0
2_1_37_00001038_12345037_deadbeef_00000000_0f_12345000_00001038_0
2_1_17_0000103c_00002017_00000000_00000000_10_0000303c_0000103c_0
2_0_00_00000000_00000000_00000000_00000000_00_00000000_00000000_0
// group 3: JAL and JALR, forward and backward
3_1_6f_00002000_1000006f_00000000_00000000_11_00002004_00002100_1
3_1_6f_00002010_ff9ff06f_00000000_00000000_12_00002014_00002008_1
3_1_67_00002020_01100067_00003000_00000000_13_00002024_00003010_1
3_1_67_00002030_ffc00067_00004001_00000000_14_00002034_00003ffc_1
3_0_00_00000000_00000000_00000000_00000000_00_00000000_00000000_0
// group 4: six branch conditions, taken then not taken
4_1_63_00003000_04000063_00000005_00000005_15_00000000_00003040_1
4_1_63_00003004_04000063_00000005_00000006_16_00000000_00003004_0
4_1_63_00003008_04001063_00000001_00000002_17_00000000_00003048_1
4_1_63_0000300c_04001063_00000007_00000007_18_00000000_0000300c_0
4_1_63_00003010_fe0048e3_fffffffe_00000001_19_00000000_00003000_1
4_1_63_00003014_04004063_00000001_fffffffe_1a_00000000_00003014_0
4_1_63_00003018_04005063_00000003_00000003_1b_00000000_00003058_1
4_1_63_0000301c_04005063_80000000_00000000_1c_00000000_0000301c_0
4_1_63_00003020_04006063_00000001_ffffffff_1d_00000000_00003060_1
4_1_63_00003024_04006063_ffffffff_00000001_1e_00000000_00003024_0
4_1_63_00003028_fe0078e3_ffffffff_00000001_1f_00000000_00003018_1
4_1_63_0000302c_04007063_00000000_00000001_20_00000000_0000302c_0
4_0_00_00000000_00000000_00000000_00000000_00_00000000_00000000_0
// group 5: mixed ops on consecutive cycles
5_1_33_00004000_00000033_7fffffff_00000001_21_80000000_00004000_0
5_1_13_00004004_7ff00013_00000001_00000000_22_00000800_00004004_0
5_1_6f_00004008_0080006f_00000000_00000000_23_0000400c_00004010_1
5_1_33_0000400c_00004033_aaaaaaaa_55555555_24_ffffffff_0000400c_0
5_0_00_00000000_00000000_00000000_00000000_00_00000000_00000000_0
// group 6: tags 26 and 27 are dropped by the flush, expected fields unused
6_1_33_00005000_00000033_00000001_00000001_25_00000002_00005000_0
6_1_33_00005004_00000033_00000002_00000002_26_00000000_00000000_0
6_3_33_00005008_00000033_00000003_00000003_27_00000000_00000000_0
6_1_33_0000500c_00000033_00000004_00000004_28_00000008_0000500c_0
6_1_63_00005010_04000063_00000000_00000000_29_00000000_00005050_1
